//--- Makefile
TOP := tb_branch_counter_unit

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -Iverilog -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/tb_branch_counter_unit.sv
// ----------------------------
// Branch counter unit testbench.
// Table rows are applied as passes of their threads, and a model
// of the per-thread counts gives the expected running flags.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module tb_branch_counter_unit;

    import branch_pkg::*;

    // One pass of one thread on one counter.
    // ready_previous goes with the load, ready goes with the branch.
    typedef struct {
        string name;
        int    thread;
        int    counter;
        bit    load;
        int    value;
        bit    ready_previous;
        bit    branch;
        bit    ready;
    } row_t;

    logic                          clock;
    logic                          rst;
    logic [`BRANCH_COUNT-1:0]      branch_reached;
    logic                          io_ready;
    logic                          io_ready_previous;
    load_cmd_t [`BRANCH_COUNT-1:0] load_cmd;
    logic [`BRANCH_COUNT-1:0]      running;

    // Stimulus table and the model of every stored count.
    row_t   rows[$];
    int     model [`BRANCH_COUNT][`THREAD_COUNT];
    // Index of the next rising edge, counted from the first one after reset.
    int     slot;
    int     errors;
    int     timeouts;
    integer seed;

    branch_counter_unit branch_counter_unit_inst (.*);

    // Period of 10 time units.
    always #5 clock = ~clock;

    // Step to the next falling edge, where inputs change and outputs are stable.
    task automatic next_cycle();
        @(negedge clock);
        slot++;
    endtask

    // Present one row over the pass of its thread and check running three
    // cycles after the read slot.
    task automatic apply_row(input row_t r);
        int                       wait_count;
        logic [`BRANCH_COUNT-1:0] expected;
        // The thread's read slot comes around within one rotation.
        wait_count = 0;
        while (slot % `THREAD_COUNT != r.thread && wait_count < 2 * `THREAD_COUNT) begin
            next_cycle();
            wait_count++;
        end
        if (slot % `THREAD_COUNT != r.thread) begin
            $display("timeout: the read slot of thread %0d never came for %s",
                     r.thread, r.name);
            timeouts++;
        end else begin
            // Running shows the count as it stood before this pass.
            for (int i = 0; i < `BRANCH_COUNT; i++) begin
                expected[i] = model[i][r.thread] != 0;
            end
            // Read cycle: the load request and its annul level.
            load_cmd[r.counter] = '{load: r.load, value: count_t'(r.value)};
            io_ready_previous   = r.ready_previous;
            next_cycle();
            // The branch strobe follows one cycle after the read.
            load_cmd                  = '0;
            io_ready_previous         = 1'b0;
            branch_reached[r.counter] = r.branch;
            next_cycle();
            // io_ready refers to the instruction two stages past the read.
            branch_reached = '0;
            io_ready       = r.ready;
            next_cycle();
            io_ready = 1'b0;
            for (int i = 0; i < `BRANCH_COUNT; i++) begin
                assert (running[i] === expected[i]) else begin
                    errors++;
                    $display("mismatch %s: counter %0d thread %0d expected %0b actual %0b",
                             r.name, i, r.thread, expected[i], running[i]);
                end
            end
            // A taken load wins; otherwise only a running count takes the branch.
            if (r.load && r.ready_previous) begin
                model[r.counter][r.thread] = r.value;
            end else if (expected[r.counter] && r.branch && r.ready) begin
                model[r.counter][r.thread]--;
            end
        end
    endtask

    initial begin
        logic [31:0] rnd;
        clock             = 1'b0;
        rst               = 1'b1;
        branch_reached    = '0;
        io_ready          = 1'b0;
        io_ready_previous = 1'b0;
        load_cmd          = '0;
        seed              = 32'hb921_4c5a;
        errors            = 0;
        timeouts          = 0;

        // ----------------------------
        // Stimulus table.
        // After reset every thread slot reads a stopped counter.
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            rows.push_back('{"reset_idle", t, 1, 0, 0, 0, 0, 0});
        end
        // Load three, then branch on every later pass, past the end of the count.
        rows.push_back('{"load_three", 2, 0, 1, 3, 1, 0, 0});
        repeat (5) begin
            rows.push_back('{"count_down", 2, 0, 0, 0, 0, 1, 1});
        end
        // An annulled load and annulled branches leave the count as it was.
        rows.push_back('{"load_annulled", 5, 1, 1, 9, 0, 0, 0});
        rows.push_back('{"load_one", 5, 1, 1, 1, 1, 0, 0});
        rows.push_back('{"branch_annulled", 5, 1, 0, 0, 0, 1, 0});
        rows.push_back('{"branch_annulled", 5, 1, 0, 0, 0, 1, 0});
        // With a count of one a decrement would stop the counter, a load does not.
        rows.push_back('{"load_over_branch", 5, 1, 1, 6, 1, 1, 1});
        rows.push_back('{"after_load", 5, 1, 0, 0, 0, 1, 1});
        // A count with a zero lower half must borrow from the upper half.
        // Sixty-four passes run, and the next one sees the counter stopped.
        rows.push_back('{"load_borrow", 6, 0, 1, 64, 1, 0, 0});
        repeat (65) begin
            rows.push_back('{"borrow_down", 6, 0, 0, 0, 0, 1, 1});
        end
        // Random passes over all threads and both counters.
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            rows.push_back('{"random", rnd[7:0] % `THREAD_COUNT, rnd[15:8] % `BRANCH_COUNT,
                             rnd[17:16] == 2'b00, rnd[20:18], rnd[21],
                             rnd[22] | rnd[23], rnd[24] | rnd[25]});
        end

        // ----------------------------
        // Reset for four cycles, released on a falling edge.
        repeat (4) @(negedge clock);
        rst  = 1'b0;
        slot = 0;
        foreach (rows[n]) begin
            apply_row(rows[n]);
            if (timeouts != 0) begin
                break;
            end
        end
        $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/branch_counter.sv
// ----------------------------
// Branch counter.
// One multithreaded down-counter, one count per thread, with a
// running flag that stays high while the count is non-zero.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module branch_counter (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     branch_reached,
    input  wire                     io_ready,
    input  wire                     io_ready_previous,
    input  branch_pkg::load_cmd_t   load_cmd,
    output logic                    running
);

    import thread_pkg::*;
    import branch_pkg::*;

    localparam int MEM_PIPE_DEPTH       = 1;
    localparam int DECREMENT_PIPE_DEPTH = 2;
    localparam int MODULE_PIPE_DEPTH    = MEM_PIPE_DEPTH + DECREMENT_PIPE_DEPTH;

    // The load request travels together with its annul level.
    typedef struct packed {
        logic      io_ready_previous;
        load_cmd_t cmd;
    } load_path_t;

    load_path_t load_path_in;
    load_path_t load_sync;
    logic       branch_reached_sync;
    logic       io_ready_sync;
    logic       running_internal;
    logic       load_take;
    logic       wren;
    count_t     count;
    count_t     decremented_count;
    count_t     new_value;
    thread_id_t thread_read;
    thread_id_t thread_write;

    // ----------------------------
    // Input alignment.
    // Each input arrives at its own stage of the pass.
    // All of them meet the decremented count at the write-back stage.

    assign load_path_in.io_ready_previous = io_ready_previous;
    assign load_path_in.cmd               = load_cmd;

    delay_line #(.DEPTH(MODULE_PIPE_DEPTH), .payload_t(load_path_t)) load_delay_inst (
        .clock (clock),
        .rst   (rst),
        .in    (load_path_in),
        .out   (load_sync)
    );

    delay_line #(.DEPTH(DECREMENT_PIPE_DEPTH), .payload_t(logic)) branch_delay_inst (
        .clock (clock),
        .rst   (rst),
        .in    (branch_reached),
        .out   (branch_reached_sync)
    );

    // io_ready already comes one stage late, so it needs one register less.
    delay_line #(.DEPTH(DECREMENT_PIPE_DEPTH - 1), .payload_t(logic)) io_ready_delay_inst (
        .clock (clock),
        .rst   (rst),
        .in    (io_ready),
        .out   (io_ready_sync)
    );

    // ----------------------------
    // Write arbitration.
    // A branch decrements only a running counter.
    // A load is taken at any time and wins over a decrement on the same pass.
    assign load_take = load_sync.cmd.load & load_sync.io_ready_previous;
    assign wren      = (running & io_ready_sync & branch_reached_sync) | load_take;
    assign new_value = load_take ? load_sync.cmd.value : decremented_count;

    // ----------------------------
    // Thread slots.
    // The write slot trails the read slot by the pipeline depth.
    // Both then point at the same thread for one pass.

    thread_number #(.INITIAL_THREAD(0)) read_thread_inst (
        .clock          (clock),
        .rst            (rst),
        .current_thread (thread_read)
    );

    thread_number #(.INITIAL_THREAD(`THREAD_COUNT - MODULE_PIPE_DEPTH)) write_thread_inst (
        .clock          (clock),
        .rst            (rst),
        .current_thread (thread_write)
    );

    count_ram count_ram_inst (
        .clock      (clock),
        .rst        (rst),
        .wren       (wren),
        .write_addr (thread_write),
        .write_data (new_value),
        .read_addr  (thread_read),
        .read_data  (count)
    );

    // ----------------------------
    // Decrement and running flag.
    // The flag waits in a delay line for as long as the decrement takes.
    // The two are then valid together.

    count_decrement count_decrement_inst (
        .clock  (clock),
        .rst    (rst),
        .count  (count),
        .result (decremented_count)
    );

    assign running_internal = |count;

    delay_line #(.DEPTH(DECREMENT_PIPE_DEPTH), .payload_t(logic)) running_delay_inst (
        .clock (clock),
        .rst   (rst),
        .in    (running_internal),
        .out   (running)
    );

endmodule

`default_nettype wire

//--- verilog/branch_counter_unit.sv
// ----------------------------
// Branch counter unit.
// A bank of multithreaded branch counters sharing the thread
// rotation and the annul levels.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module branch_counter_unit (
    input  wire                                         clock,
    input  wire                                         rst,
    input  wire [`BRANCH_COUNT-1:0]                     branch_reached,
    input  wire                                         io_ready,
    input  wire                                         io_ready_previous,
    input  branch_pkg::load_cmd_t [`BRANCH_COUNT-1:0]   load_cmd,
    output logic [`BRANCH_COUNT-1:0]                    running
);

    // One counter per branch.
    // All of them run their thread slots in lock step from the same reset.
    for (genvar i = 0; i < `BRANCH_COUNT; i++) begin : gen_counter
        branch_counter branch_counter_inst (
            .clock             (clock),
            .rst               (rst),
            .branch_reached    (branch_reached[i]),
            .io_ready          (io_ready),
            .io_ready_previous (io_ready_previous),
            .load_cmd          (load_cmd[i]),
            .running           (running[i])
        );
    end

endmodule

`default_nettype wire

//--- verilog/branch_defines.svh
// ----------------------------
// Branch counter build constants.
// Thread rotation size and the widths of the words that the
// branch counters keep per thread.
// ----------------------------

`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// Number of threads in the barrel rotation, one per clock.
`define THREAD_COUNT 8

// Bits needed to name one thread.
`define THREAD_ID_WIDTH 3

// Width of one stored branch count.
`define COUNT_WIDTH 12

// Number of independent branch counters in the unit.
`define BRANCH_COUNT 2

`endif

//--- verilog/branch_pkg.sv
// ----------------------------
// Branch counting types.
// The count word and the per-counter load request.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

package branch_pkg;

    // One stored branch count.
    // A non-zero value means the loop is still running.
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // Load request of the current instruction for one counter.
    // The value is only taken when load is high and the instruction is not annulled.
    typedef struct packed {
        logic   load;
        count_t value;
    } load_cmd_t;

endpackage

`default_nettype wire

//--- verilog/count_decrement.sv
// ----------------------------
// Count decrement.
// Subtracts one from a count word over two register stages.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module count_decrement (
    input  wire                 clock,
    input  wire                 rst,
    input  branch_pkg::count_t  count,
    output branch_pkg::count_t  result
);

    // Split of the word between the two stages.
    localparam int LOW_WIDTH  = `COUNT_WIDTH / 2;
    localparam int HIGH_WIDTH = `COUNT_WIDTH - LOW_WIDTH;

    logic [LOW_WIDTH:0]      low_diff;
    logic [LOW_WIDTH-1:0]    low_q;
    logic                    borrow_q;
    logic [HIGH_WIDTH-1:0]   high_q;

    // The extra top bit goes high exactly when the lower half was zero.
    assign low_diff = {1'b0, count[LOW_WIDTH-1:0]} - 1'b1;

    // ----------------------------
    // Stage 1: lower half, borrow out, upper half carried along.
    always_ff @(posedge clock) begin
        if (rst) begin
            low_q    <= '0;
            borrow_q <= 1'b0;
            high_q   <= '0;
        end else begin
            low_q    <= low_diff[LOW_WIDTH-1:0];
            borrow_q <= low_diff[LOW_WIDTH];
            high_q   <= count[`COUNT_WIDTH-1:LOW_WIDTH];
        end
    end

    // ----------------------------
    // Stage 2: upper half takes the borrow.
    // Zero wraps to all ones, but a stopped counter is never written back.
    always_ff @(posedge clock) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= {high_q - HIGH_WIDTH'(borrow_q), low_q};
        end
    end

endmodule

`default_nettype wire

//--- verilog/count_ram.sv
// ----------------------------
// Count memory.
// One count word per thread, simple dual port with a registered
// read, cleared by reset.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module count_ram (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     wren,
    input  thread_pkg::thread_id_t  write_addr,
    input  branch_pkg::count_t      write_data,
    input  thread_pkg::thread_id_t  read_addr,
    output branch_pkg::count_t      read_data
);

    import thread_pkg::*;
    import branch_pkg::*;

    // One word per thread slot.
    count_t mem [`THREAD_COUNT];

    always_ff @(posedge clock) begin
        if (rst) begin
            // Every thread starts with a stopped counter.
            for (int i = 0; i < `THREAD_COUNT; i++) begin
                mem[i] <= '0;
            end
            read_data <= '0;
        end else begin
            if (wren) begin
                mem[write_addr] <= write_data;
            end
            // A read on the same edge as a write to that word returns the old data.
            // The rotation keeps the two ports on different threads anyway.
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/delay_line.sv
// ----------------------------
// Delay line.
// Fixed-depth register pipeline for any payload type.
// ----------------------------

`default_nettype none

module delay_line #(
    parameter int DEPTH = 1,
    parameter type payload_t = logic
) (
    input  wire      clock,
    input  wire      rst,
    input  payload_t in,
    output payload_t out
);

    // Stage 0 takes the input; the last stage drives the output.
    payload_t stages [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            // Every other stage shifts one step down the chain.
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Exactly DEPTH clocks from in to out.
    assign out = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/thread_number.sv
// ----------------------------
// Thread number.
// Round-robin thread slot counter with a chosen start value.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

module thread_number #(
    parameter int INITIAL_THREAD = 0
) (
    input  wire                     clock,
    input  wire                     rst,
    output thread_pkg::thread_id_t  current_thread
);

    import thread_pkg::*;

    // Highest thread number before the count wraps to zero.
    localparam thread_id_t LAST_THREAD = thread_id_t'(`THREAD_COUNT - 1);

    // Advance one thread per clock.
    // The start value sets how far this counter trails or leads other instances.
    always_ff @(posedge clock) begin
        if (rst) begin
            current_thread <= thread_id_t'(INITIAL_THREAD);
        end else if (current_thread == LAST_THREAD) begin
            current_thread <= '0;
        end else begin
            current_thread <= current_thread + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/thread_pkg.sv
// ----------------------------
// Thread rotation types.
// Names a thread slot in the barrel round robin.
// ----------------------------

`default_nettype none

`include "branch_defines.svh"

package thread_pkg;

    // One thread number.
    // It wraps at THREAD_COUNT, so not every code is used when the count is not a power of two.
    typedef logic [`THREAD_ID_WIDTH-1:0] thread_id_t;

endpackage

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/thread_pkg.sv
verilog/branch_pkg.sv
verilog/delay_line.sv
verilog/thread_number.sv
verilog/count_ram.sv
verilog/count_decrement.sv
verilog/branch_counter.sv
verilog/branch_counter_unit.sv
bench/tb_branch_counter_unit.sv
